// File: rob.f
+incdir+.
rob_pkg.sv
rob_if.sv
rob_pointers.sv
rob_entry.sv
rob_commit.sv
rob_top.sv
tb_rob.sv

// File: rob_commit.sv
`include "rob_consts.svh"

module rob_commit
  import rob_pkg::*;
(
  input  rob_entry_t i_entries [`ROB_ENTRIES],
  input  cmt_id_t    i_out_id,
  output logic       o_retire,
  output logic       o_kill,
  output logic       o_commit_valid,
  output cmt_id_t    o_commit_cmt_id,
  output slot_mask_t o_commit_grp,
  output slot_mask_t o_commit_dead,
  output logic       o_commit_except_valid,
  output exc_code_t  o_commit_except_code,
  output pc_t        o_commit_epc,
  output pc_t        o_commit_tval,
  output logic       o_commit_flush
);

  rob_entry_t w_head;
  logic       w_all_done;
  slot_mask_t w_upd_pc;     // slots that redirect the pc
  slot_mask_t w_upd_oh;     // lowest of them
  slot_mask_t w_from_upd;   // that slot and everything after
  slot_mask_t w_after_upd;  // strictly after
  slot_mask_t w_exc_oh;
  logic       w_exc_hit;
  slot_mask_t w_new_dead;
  slot_idx_t  w_exc_idx;
  exc_code_t  w_exc_code;
  pc_t        w_exc_tval;

  assign w_head = i_entries[i_out_id[`ROB_ENTRY_W-1:0]];

  // whole group finished, dead slots count as done
  assign w_all_done = w_head.valid && ((w_head.grp & ~w_head.done) == '0);

  // --------------------
  // pc update select
  // --------------------
  assign w_upd_pc = (w_head.except_valid | w_head.mispredict) & w_head.grp;
  assign w_upd_oh = w_upd_pc & (~w_upd_pc + 1'b1);  // isolate lowest set bit

  assign w_from_upd  = (w_upd_oh != '0) ? ~(w_upd_oh - 1'b1) : '0;
  assign w_after_upd = w_from_upd & ~w_upd_oh;

  // an exception wins over a mispredict in the same slot
  assign w_exc_oh  = w_upd_oh & w_head.except_valid;
  assign w_exc_hit = (w_exc_oh != '0);

  // exception kills itself too, a branch only what follows it
  assign w_new_dead = w_exc_hit ? w_from_upd : w_after_upd;

  // one-hot pick of the excepting slot
  always_comb begin
    w_exc_idx  = '0;
    w_exc_code = '0;
    w_exc_tval = '0;
    for (int s = 0; s < `ROB_DISP_WIDTH; s++) begin
      if (w_exc_oh[s]) begin
        w_exc_idx  = slot_idx_t'(s);
        w_exc_code = w_head.except_code[s];
        w_exc_tval = w_head.tval[s];
      end
    end
  end

  // --------------------
  // commit outputs
  // --------------------
  assign o_commit_valid        = w_all_done;
  assign o_commit_cmt_id       = i_out_id;
  assign o_commit_grp          = w_head.grp;
  assign o_commit_dead         = (w_head.dead | w_new_dead) & w_head.grp;
  assign o_commit_except_valid = w_all_done & w_exc_hit;
  assign o_commit_except_code  = w_exc_code;
  assign o_commit_epc          = w_head.pc + (pc_t'(w_exc_idx) << 2);  // 4 bytes per slot
  assign o_commit_tval         = w_exc_tval;
  assign o_commit_flush        = w_all_done & w_exc_hit;

  assign o_retire = w_all_done;
  assign o_kill   = o_commit_flush;  // all younger groups go

endmodule

// File: rob_consts.svh
`ifndef ROB_CONSTS_SVH
`define ROB_CONSTS_SVH

// --------------------
// buffer geometry
// --------------------
`define ROB_ENTRIES     8    // groups in flight
`define ROB_ENTRY_W     3    // index bits, wrap bit sits above

// --------------------
// group and port shape
// --------------------
`define ROB_DISP_WIDTH  4    // slots per dispatch group
`define ROB_DONE_PORTS  2    // parallel completion ports

// --------------------
// data widths
// --------------------
`define ROB_PC_W        32   // byte address
`define ROB_EXC_W       5    // exception cause width

// cause code used for slots that fail decode at dispatch
`define ROB_EXC_ILLEGAL 2

`endif

// File: rob_entry.sv
`include "rob_consts.svh"

module rob_entry
  import rob_pkg::*;
(
  input  logic                    i_clk,
  input  logic                    i_reset_n,
  input  logic [`ROB_ENTRY_W-1:0] i_index,         // this entry's slot in the buffer
  input  logic                    i_load,
  input  slot_mask_t              i_disp_grp,
  input  slot_mask_t              i_disp_illegal,
  input  pc_t                     i_disp_pc,
  input  logic                    i_kill,          // older group flushed
  input  logic                    i_retire,
  done_rpt_if.sink                done_rpt,
  br_upd_if.sink                  br_upd,
  output rob_entry_t              o_entry
);

  // control state
  logic       r_valid;
  slot_mask_t r_done;
  slot_mask_t r_except_valid;
  slot_mask_t r_dead;
  slot_mask_t r_mispredict;

  // payload
  pc_t                             r_pc;
  slot_mask_t                      r_grp;
  exc_code_t [`ROB_DISP_WIDTH-1:0] r_except_code;
  pc_t       [`ROB_DISP_WIDTH-1:0] r_tval;

  rob_entry_t w_next;

  assign o_entry = '{valid:        r_valid,
                     pc:           r_pc,
                     grp:          r_grp,
                     done:         r_done,
                     except_valid: r_except_valid,
                     dead:         r_dead,
                     mispredict:   r_mispredict,
                     except_code:  r_except_code,
                     tval:         r_tval};

  // --------------------
  // next state
  // --------------------
  always_comb begin
    w_next = o_entry;
    if (i_load) begin
      w_next.valid        = 1'b1;
      w_next.pc           = i_disp_pc;
      w_next.grp          = i_disp_grp;
      w_next.done         = i_disp_grp & i_disp_illegal;  // illegal slots never execute
      w_next.except_valid = i_disp_grp & i_disp_illegal;
      w_next.dead         = '0;
      w_next.mispredict   = '0;
      for (int s = 0; s < `ROB_DISP_WIDTH; s++) begin
        w_next.except_code[s] = exc_code_t'(`ROB_EXC_ILLEGAL);
        w_next.tval[s]        = '0;
      end
      if (i_kill) begin  // dispatched under a flush
        w_next.done         = i_disp_grp;
        w_next.dead         = i_disp_grp;
        w_next.except_valid = '0;
      end
    end else if (o_entry.valid) begin
      for (int p = 0; p < `ROB_DONE_PORTS; p++) begin
        if (done_rpt.valid[p] && (done_rpt.cmt_id[p][`ROB_ENTRY_W-1:0] == i_index)) begin
          w_next.done[done_rpt.slot[p]] = 1'b1;
          if (done_rpt.except_valid[p] && !o_entry.dead[done_rpt.slot[p]]) begin
            w_next.except_valid[done_rpt.slot[p]] = 1'b1;
            w_next.except_code[done_rpt.slot[p]]  = done_rpt.except_code[p];
            w_next.tval[done_rpt.slot[p]]         = done_rpt.tval[p];
          end
        end
      end
      if (br_upd.valid && br_upd.mispredict &&
          (br_upd.cmt_id[`ROB_ENTRY_W-1:0] == i_index) && !o_entry.dead[br_upd.slot]) begin
        w_next.mispredict[br_upd.slot] = 1'b1;
      end
      // kill overrides anything reported this cycle
      if (i_kill) begin
        w_next.done         = o_entry.grp;
        w_next.dead         = o_entry.grp;
        w_next.except_valid = '0;
        w_next.mispredict   = '0;
      end
      if (i_retire) begin
        w_next.valid = 1'b0;
      end
    end
  end

  // --------------------
  // registers
  // --------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid        <= 1'b0;
      r_done         <= '0;
      r_except_valid <= '0;
      r_dead         <= '0;
      r_mispredict   <= '0;
    end else begin
      r_valid        <= w_next.valid;
      r_done         <= w_next.done;
      r_except_valid <= w_next.except_valid;
      r_dead         <= w_next.dead;
      r_mispredict   <= w_next.mispredict;
    end
  end

  always_ff @(posedge i_clk) begin
    r_pc          <= w_next.pc;
    r_grp         <= w_next.grp;
    r_except_code <= w_next.except_code;
    r_tval        <= w_next.tval;
  end

  // a report only targets a group that is still in flight
  for (genvar p = 0; p < `ROB_DONE_PORTS; p++) begin : g_rpt_chk
    a_rpt_to_valid: assert property (@(posedge i_clk) disable iff (!i_reset_n)
      (done_rpt.valid[p] && (done_rpt.cmt_id[p][`ROB_ENTRY_W-1:0] == i_index)) |-> r_valid)
      else $error("rob_entry %0d: report on port %0d to an empty entry", i_index, p);
  end

endmodule

// File: rob_if.sv
`include "rob_consts.svh"

// --------------------
// completion reports
// --------------------
// one set of fields per port, all ports valid in the same cycle
interface done_rpt_if
  import rob_pkg::*;
();

  logic      [`ROB_DONE_PORTS-1:0] valid;
  cmt_id_t   [`ROB_DONE_PORTS-1:0] cmt_id;
  slot_idx_t [`ROB_DONE_PORTS-1:0] slot;
  logic      [`ROB_DONE_PORTS-1:0] except_valid;
  exc_code_t [`ROB_DONE_PORTS-1:0] except_code;
  pc_t       [`ROB_DONE_PORTS-1:0] tval;

  modport source (output valid, cmt_id, slot, except_valid, except_code, tval);
  modport sink   (input  valid, cmt_id, slot, except_valid, except_code, tval);

endinterface

// --------------------
// branch resolution
// --------------------
interface br_upd_if
  import rob_pkg::*;
();

  logic      valid;
  cmt_id_t   cmt_id;
  slot_idx_t slot;
  logic      mispredict;  // resolved target differs from predicted

  modport source (output valid, cmt_id, slot, mispredict);
  modport sink   (input  valid, cmt_id, slot, mispredict);

endinterface

// File: rob_pkg.sv
`include "rob_consts.svh"

package rob_pkg;

  // --------------------
  // basic fields
  // --------------------

  // entry index plus wrap bit on top
  typedef logic [`ROB_ENTRY_W:0] cmt_id_t;

  // one bit per dispatch slot
  typedef logic [`ROB_DISP_WIDTH-1:0] slot_mask_t;

  // position of a slot inside its group
  typedef logic [$clog2(`ROB_DISP_WIDTH)-1:0] slot_idx_t;

  typedef logic [`ROB_EXC_W-1:0] exc_code_t;

  typedef logic [`ROB_PC_W-1:0] pc_t;

  // --------------------
  // buffer entry
  // --------------------
  // one dispatched group, slot 0 sits at pc, slot n at pc + 4n
  typedef struct packed {
    logic       valid;
    pc_t        pc;            // pc of slot 0
    slot_mask_t grp;           // slots holding an instruction
    slot_mask_t done;          // completed (or known dead)
    slot_mask_t except_valid;  // slot raised an exception
    slot_mask_t dead;          // killed by an older flush
    slot_mask_t mispredict;    // branch went the other way
    exc_code_t [`ROB_DISP_WIDTH-1:0] except_code;
    pc_t       [`ROB_DISP_WIDTH-1:0] tval;
  } rob_entry_t;

endpackage

// File: rob_pointers.sv
`include "rob_consts.svh"

module rob_pointers
  import rob_pkg::*;
(
  input  logic    i_clk,
  input  logic    i_reset_n,
  input  logic    i_alloc,          // one group dispatched
  input  logic    i_retire,         // head group committed
  output cmt_id_t o_in_id,
  output cmt_id_t o_out_id,
  output logic    o_credit_return
);

  cmt_id_t r_in_id;
  cmt_id_t r_out_id;
  logic    w_full;
  logic    w_empty;

  // step the index, flip the wrap bit when it rolls over
  function automatic cmt_id_t next_id(cmt_id_t id);
    cmt_id_t ret;
    ret = id;
    if (id[`ROB_ENTRY_W-1:0] == `ROB_ENTRY_W'(`ROB_ENTRIES - 1)) begin
      ret[`ROB_ENTRY_W-1:0] = '0;
      ret[`ROB_ENTRY_W]     = ~id[`ROB_ENTRY_W];
    end else begin
      ret[`ROB_ENTRY_W-1:0] = id[`ROB_ENTRY_W-1:0] + 1'b1;
    end
    return ret;
  endfunction

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_in_id  <= '0;
      r_out_id <= '0;
    end else begin
      if (i_alloc) begin
        r_in_id <= next_id(r_in_id);
      end
      if (i_retire) begin
        r_out_id <= next_id(r_out_id);
      end
    end
  end

  // same index, different lap
  assign w_full  = (r_in_id[`ROB_ENTRY_W-1:0] == r_out_id[`ROB_ENTRY_W-1:0]) &&
                   (r_in_id[`ROB_ENTRY_W] != r_out_id[`ROB_ENTRY_W]);
  assign w_empty = (r_in_id == r_out_id);

  assign o_in_id         = r_in_id;
  assign o_out_id        = r_out_id;
  assign o_credit_return = i_retire;  // one credit back per commit

  // sender must hold a credit, so a full buffer never sees a dispatch
  a_alloc_not_full: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_alloc |-> !w_full)
    else $error("rob_pointers: dispatch into a full buffer");

  a_retire_not_empty: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_retire |-> !w_empty)
    else $error("rob_pointers: commit from an empty buffer");

endmodule

// File: rob_stimulus.txt
# D grp pc illegal | R port id slot exc code tval | B id slot mispredict | W cycles
# E id grp dead exc code epc tval flush  (all fields hex, one op per cycle except E)
D 3 1000 0
D 7 2000 0
E 0 3 0 0 0 0 0 0
E 1 7 0 0 0 0 0 0
R 1 1 2 0 0 0
R 0 0 1 0 0 0
R 1 1 0 0 0 0
R 0 1 1 0 0 0
R 1 0 0 0 0 0
W 3
E 2 6 6 1 2 3004 0 1
E 3 1 1 0 0 0 0 0
D 6 3000 6
D 1 4000 0
W 2
E 4 7 6 1 5 5004 1234 1
E 5 3 3 0 0 0 0 0
E 6 1 1 0 0 0 0 0
D 7 5000 0
D 3 6000 0
D 1 7000 0
R 0 4 2 1 d bad3
R 1 4 1 1 5 1234
R 1 5 0 0 0 0
R 0 4 0 0 0 0
W 4
E 7 3 2 0 0 0 0 0
E 8 1 0 0 0 0 0 0
D 3 8000 0
D 1 9000 0
B 7 0 1
R 0 7 0 0 0 0
R 1 7 1 0 0 0
R 0 8 0 0 0 0
W 4

// File: rob_top.sv
`include "rob_consts.svh"

module rob_top
  import rob_pkg::*;
(
  input  logic                                i_clk,
  input  logic                                i_reset_n,

  // dispatch, credit based
  input  logic                                i_disp_valid,
  input  slot_mask_t                          i_disp_grp,
  input  pc_t                                 i_disp_pc,
  input  slot_mask_t                          i_disp_illegal,
  output cmt_id_t                             o_disp_cmt_id,

  // completion ports
  input  logic      [`ROB_DONE_PORTS-1:0]     i_done_valid,
  input  cmt_id_t   [`ROB_DONE_PORTS-1:0]     i_done_cmt_id,
  input  slot_idx_t [`ROB_DONE_PORTS-1:0]     i_done_slot,
  input  logic      [`ROB_DONE_PORTS-1:0]     i_done_except_valid,
  input  exc_code_t [`ROB_DONE_PORTS-1:0]     i_done_except_code,
  input  pc_t       [`ROB_DONE_PORTS-1:0]     i_done_tval,

  // branch resolution
  input  logic                                i_br_valid,
  input  cmt_id_t                             i_br_cmt_id,
  input  slot_idx_t                           i_br_slot,
  input  logic                                i_br_mispredict,

  // commit
  output logic                                o_commit_valid,
  output cmt_id_t                             o_commit_cmt_id,
  output slot_mask_t                          o_commit_grp,
  output slot_mask_t                          o_commit_dead,
  output logic                                o_commit_except_valid,
  output exc_code_t                           o_commit_except_code,
  output pc_t                                 o_commit_epc,
  output pc_t                                 o_commit_tval,
  output logic                                o_commit_flush,
  output logic                                o_credit_return
);

  cmt_id_t    w_in_id;
  cmt_id_t    w_out_id;
  logic       w_retire;
  logic       w_kill;
  rob_entry_t w_entries [`ROB_ENTRIES];

  done_rpt_if u_done_rpt ();
  br_upd_if   u_br_upd ();

  // --------------------
  // pack report ports
  // --------------------
  assign u_done_rpt.valid        = i_done_valid;
  assign u_done_rpt.cmt_id       = i_done_cmt_id;
  assign u_done_rpt.slot         = i_done_slot;
  assign u_done_rpt.except_valid = i_done_except_valid;
  assign u_done_rpt.except_code  = i_done_except_code;
  assign u_done_rpt.tval         = i_done_tval;

  assign u_br_upd.valid      = i_br_valid;
  assign u_br_upd.cmt_id     = i_br_cmt_id;
  assign u_br_upd.slot       = i_br_slot;
  assign u_br_upd.mispredict = i_br_mispredict;

  rob_pointers u_pointers (
    .i_clk           (i_clk),
    .i_reset_n       (i_reset_n),
    .i_alloc         (i_disp_valid),
    .i_retire        (w_retire),
    .o_in_id         (w_in_id),
    .o_out_id        (w_out_id),
    .o_credit_return (o_credit_return)
  );

  assign o_disp_cmt_id = w_in_id;  // id handed out this cycle

  // --------------------
  // entry array
  // --------------------
  for (genvar c = 0; c < `ROB_ENTRIES; c++) begin : g_entry
    rob_entry u_entry (
      .i_clk          (i_clk),
      .i_reset_n      (i_reset_n),
      .i_index        (`ROB_ENTRY_W'(c)),
      .i_load         (i_disp_valid && (w_in_id[`ROB_ENTRY_W-1:0] == `ROB_ENTRY_W'(c))),
      .i_disp_grp     (i_disp_grp),
      .i_disp_illegal (i_disp_illegal),
      .i_disp_pc      (i_disp_pc),
      .i_kill         (w_kill),
      .i_retire       (w_retire && (w_out_id[`ROB_ENTRY_W-1:0] == `ROB_ENTRY_W'(c))),
      .done_rpt       (u_done_rpt.sink),
      .br_upd         (u_br_upd.sink),
      .o_entry        (w_entries[c])
    );
  end

  rob_commit u_commit (
    .i_entries             (w_entries),
    .i_out_id              (w_out_id),
    .o_retire              (w_retire),
    .o_kill                (w_kill),
    .o_commit_valid        (o_commit_valid),
    .o_commit_cmt_id       (o_commit_cmt_id),
    .o_commit_grp          (o_commit_grp),
    .o_commit_dead         (o_commit_dead),
    .o_commit_except_valid (o_commit_except_valid),
    .o_commit_except_code  (o_commit_except_code),
    .o_commit_epc          (o_commit_epc),
    .o_commit_tval         (o_commit_tval),
    .o_commit_flush        (o_commit_flush)
  );

endmodule

// File: tb_rob.sv
`include "rob_consts.svh"

module tb_rob
  import rob_pkg::*;
();

  localparam string STIM_FILE       = "rob_stimulus.txt";
  localparam int    CYCLES_PER_LINE = 20;  // timeout margin per stimulus line
  localparam int    MAX_LINES       = 64;

  // one expected commit record
  typedef struct packed {
    cmt_id_t    id;
    slot_mask_t grp;
    slot_mask_t dead;
    logic       exc;
    exc_code_t  code;
    pc_t        epc;
    pc_t        tval;
    logic       flush;
  } commit_rec_t;

  // dut ports under the rob_top names
  logic                                i_clk;
  logic                                i_reset_n;
  logic                                i_disp_valid;
  slot_mask_t                          i_disp_grp;
  pc_t                                 i_disp_pc;
  slot_mask_t                          i_disp_illegal;
  cmt_id_t                             o_disp_cmt_id;
  logic      [`ROB_DONE_PORTS-1:0]     i_done_valid;
  cmt_id_t   [`ROB_DONE_PORTS-1:0]     i_done_cmt_id;
  slot_idx_t [`ROB_DONE_PORTS-1:0]     i_done_slot;
  logic      [`ROB_DONE_PORTS-1:0]     i_done_except_valid;
  exc_code_t [`ROB_DONE_PORTS-1:0]     i_done_except_code;
  pc_t       [`ROB_DONE_PORTS-1:0]     i_done_tval;
  logic                                i_br_valid;
  cmt_id_t                             i_br_cmt_id;
  slot_idx_t                           i_br_slot;
  logic                                i_br_mispredict;
  logic                                o_commit_valid;
  cmt_id_t                             o_commit_cmt_id;
  slot_mask_t                          o_commit_grp;
  slot_mask_t                          o_commit_dead;
  logic                                o_commit_except_valid;
  exc_code_t                           o_commit_except_code;
  pc_t                                 o_commit_epc;
  pc_t                                 o_commit_tval;
  logic                                o_commit_flush;
  logic                                o_credit_return;

  // stimulus table and bookkeeping
  byte         ops  [MAX_LINES];
  logic [31:0] args [MAX_LINES][8];
  int          n_ops   = 0;
  int          limit   = 0;
  int          cycles  = 0;
  int          credits = `ROB_ENTRIES;  // sender side credit count
  cmt_id_t     exp_disp_id = '0;        // id the next dispatch should get
  commit_rec_t exp_q [$];

  rob_top dut (.*);

  initial begin
    i_clk = 1'b0;
    forever #5 i_clk = ~i_clk;
  end

  // --------------------
  // helpers
  // --------------------
  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic check_field(input string name, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
    assert (exp_v === act_v)
      else report_failure($sformatf("CHECK FAILED at %0t: %s expected %0h actual %0h",
                                    $time, name, exp_v, act_v));
  endtask

  task automatic drive_idle();
    i_disp_valid        = 1'b0;
    i_disp_grp          = '0;
    i_disp_pc           = '0;
    i_disp_illegal      = '0;
    i_done_valid        = '0;
    i_done_cmt_id       = '0;
    i_done_slot         = '0;
    i_done_except_valid = '0;
    i_done_except_code  = '0;
    i_done_tval         = '0;
    i_br_valid          = 1'b0;
    i_br_cmt_id         = '0;
    i_br_slot           = '0;
    i_br_mispredict     = 1'b0;
  endtask

  // whole file parsed up front so the timeout is known before reset ends
  task automatic load_stimulus();
    int    fd;
    string line;
    fd = $fopen(STIM_FILE, "r");
    assert (fd != 0) else report_failure("cannot open the stimulus file");
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() < 2 || line[0] == "#") continue;  // blank or column notes
      assert (n_ops < MAX_LINES) else report_failure("stimulus file has too many lines");
      void'($sscanf(line, "%c %h %h %h %h %h %h %h %h", ops[n_ops],
                    args[n_ops][0], args[n_ops][1], args[n_ops][2], args[n_ops][3],
                    args[n_ops][4], args[n_ops][5], args[n_ops][6], args[n_ops][7]));
      limit += CYCLES_PER_LINE;
      if (ops[n_ops] == "W") limit += args[n_ops][0];
      n_ops++;
    end
    $fclose(fd);
  endtask

  task automatic run_op(input int k);
    int p;
    p = args[k][0];
    case (ops[k])
      "E": exp_q.push_back('{id: cmt_id_t'(args[k][0]), grp: slot_mask_t'(args[k][1]),
                             dead: slot_mask_t'(args[k][2]), exc: args[k][3][0],
                             code: exc_code_t'(args[k][4]), epc: args[k][5],
                             tval: args[k][6], flush: args[k][7][0]});
      "D": begin
        assert (credits > 0) else report_failure("dispatch attempted with no credit left");
        credits--;
        i_disp_valid   = 1'b1;
        i_disp_grp     = slot_mask_t'(args[k][0]);
        i_disp_pc      = args[k][1];
        i_disp_illegal = slot_mask_t'(args[k][2]);
      end
      "R": begin
        i_done_valid[p]        = 1'b1;
        i_done_cmt_id[p]       = cmt_id_t'(args[k][1]);
        i_done_slot[p]         = slot_idx_t'(args[k][2]);
        i_done_except_valid[p] = args[k][3][0];
        i_done_except_code[p]  = exc_code_t'(args[k][4]);
        i_done_tval[p]         = args[k][5];
      end
      "B": begin
        i_br_valid      = 1'b1;
        i_br_cmt_id     = cmt_id_t'(args[k][0]);
        i_br_slot       = slot_idx_t'(args[k][1]);
        i_br_mispredict = args[k][2][0];
      end
      "W": repeat (args[k][0]) @(posedge i_clk);
      default: report_failure("unknown operation in the stimulus file");
    endcase
    if (ops[k] != "E") begin
      if (ops[k] != "W") @(posedge i_clk);  // one op per cycle
      #1 drive_idle();
    end
  endtask

  // --------------------
  // main sequence
  // --------------------
  initial begin
    i_reset_n = 1'b0;
    drive_idle();
    load_stimulus();
    repeat (10) @(posedge i_clk);
    #1 i_reset_n = 1'b1;
    for (int k = 0; k < n_ops; k++) begin
      run_op(k);
    end
    while (exp_q.size() > 0) @(posedge i_clk);
    repeat (3) @(posedge i_clk);  // catch any extra commit
    if (credits == `ROB_ENTRIES) begin
      $display("Verification passed");
      $finish;
    end else begin
      report_failure($sformatf("CHECK FAILED at %0t: credits expected %0d actual %0d",
                               $time, `ROB_ENTRIES, credits));
    end
  end

  // --------------------
  // commit and credit monitor
  // --------------------
  always @(negedge i_clk) begin : b_monitor
    commit_rec_t rec;
    if (i_reset_n) begin
      if (i_disp_valid) begin  // ids go out in order, wrap bit flips each lap
        check_field("o_disp_cmt_id", exp_disp_id, o_disp_cmt_id);
        exp_disp_id = cmt_id_t'((exp_disp_id + 1) % (2 * `ROB_ENTRIES));
      end
      if (o_credit_return) begin
        assert (o_commit_valid) else report_failure("credit returned without a commit");
        credits++;
      end
      if (o_commit_valid) begin
        assert (exp_q.size() > 0) else report_failure("commit seen with no record expected");
        rec = exp_q.pop_front();
        check_field("o_commit_cmt_id", rec.id, o_commit_cmt_id);
        check_field("o_commit_grp", rec.grp, o_commit_grp);
        check_field("o_commit_dead", rec.dead, o_commit_dead);
        check_field("o_commit_except_valid", rec.exc, o_commit_except_valid);
        check_field("o_commit_flush", rec.flush, o_commit_flush);
        if (rec.exc) begin  // cause fields only mean something on an exception
          check_field("o_commit_except_code", rec.code, o_commit_except_code);
          check_field("o_commit_epc", rec.epc, o_commit_epc);
          check_field("o_commit_tval", rec.tval, o_commit_tval);
        end
      end
    end
  end

  // run limit from the stimulus length
  always @(posedge i_clk) begin
    if (i_reset_n) begin
      cycles++;
      if (cycles > limit) begin
        report_failure($sformatf("timeout after %0d cycles with commits still missing",
                                 cycles));
      end
    end
  end

endmodule
